// File: filelist.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_memory.sv
source/rv_core.sv
test/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_rv_core \
    -f filelist.f \
    -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi
echo "run.sh: simulation failed, see sim.log"
exit 1

// File: source/rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               load_req,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [31:0]        load_data,
    output logic               load_ack,
    output retire_t            retire,
    output store_t             store
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    logic        stall;
    logic        redirect;
    logic        flush;
    logic [31:0] target;

    rv_fetch i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .if_id     (if_id)
    );

    rv_decode i_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .if_id  (if_id),
        .mem_wb (mem_wb),
        .flush  (flush),
        .stall  (stall),
        .id_ex  (id_ex)
    );

    rv_execute i_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .mem_wb   (mem_wb),
        .ex_mem   (ex_mem),
        .redirect (redirect),
        .flush    (flush),
        .target   (target)
    );

    rv_memory i_memory (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .store  (store)
    );

    // Writes to x0 are not reported.
    assign retire = '{valid: mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != 5'd0),
                      rd: mem_wb.rd, data: wb_data(mem_wb)};

endmodule

// File: source/rv_decode.sv
module rv_decode import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    input  logic    flush,
    output logic    stall,
    output id_ex_t  id_ex
);

    logic [31:0] instr;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic        uses_rs2;
    ctrl_t       ctrl;

    assign instr  = if_id.instr;
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (mem_wb.valid && mem_wb.reg_write),
        .rd       (mem_wb.rd),
        .wd       (wb_data(mem_wb))
    );

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr[6:0])
            op_reg: begin
                ctrl.reg_write = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000) ctrl.alu_op = alu_add;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000) ctrl.alu_op = alu_sub;
                else if (funct3 == 3'b111 && funct7 == 7'b0000000) ctrl.alu_op = alu_and;
                else if (funct3 == 3'b110 && funct7 == 7'b0000000) ctrl.alu_op = alu_or;
                else if (funct3 == 3'b010 && funct7 == 7'b0000000) ctrl.alu_op = alu_slt;
                else ctrl = '0;
            end
            op_imm: begin
                // addi only.
                if (funct3 == 3'b000) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.alu_src    = 1'b1;
                end
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                if (funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = alu_sub;
                end
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: ctrl = '0;
        endcase
    end

    // R-type, store and branch read rs2.
    assign uses_rs2 = !ctrl.alu_src || ctrl.mem_write;

    // Load-use hazard.
    assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != 5'd0)
                   && ((id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (flush || stall || !if_id.valid) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{valid: 1'b1, ctrl: ctrl, pc: if_id.pc, rs1_data: rs1_data,
                       rs2_data: rs2_data, imm: imm, rs1: rs1, rs2: rs2, rd: rd};
        end
    end

endmodule

// File: source/rv_execute.sv
module rv_execute import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  id_ex_t      id_ex,
    input  mem_wb_t     mem_wb,
    output ex_mem_t     ex_mem,
    output logic        redirect,
    output logic        flush,
    output logic [31:0] target
);

    logic [31:0] wb_val;
    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;

    // Newest producer wins; x0 is never forwarded.
    function automatic logic [31:0] fwd(
        logic [4:0]  rs,
        logic [31:0] rf_data,
        ex_mem_t     em,
        mem_wb_t     mw,
        logic [31:0] mw_data
    );
        if (em.valid && em.ctrl.reg_write && em.rd != 5'd0 && em.rd == rs) begin
            return em.alu_result;
        end
        if (mw.valid && mw.reg_write && mw.rd != 5'd0 && mw.rd == rs) begin
            return mw_data;
        end
        return rf_data;
    endfunction

    assign wb_val = wb_data(mem_wb);
    assign fwd_a  = fwd(id_ex.rs1, id_ex.rs1_data, ex_mem, mem_wb, wb_val);
    assign fwd_b  = fwd(id_ex.rs2, id_ex.rs2_data, ex_mem, mem_wb, wb_val);

    // Second operand is the immediate for addi, lw and sw.
    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: alu_result = fwd_a + alu_b;
            alu_sub: alu_result = fwd_a - alu_b;
            alu_and: alu_result = fwd_a & alu_b;
            alu_or:  alu_result = fwd_a | alu_b;
            alu_slt: alu_result = {31'd0, $signed(fwd_a) < $signed(alu_b)};
            default: alu_result = '0;
        endcase
    end

    // beq resolves here.
    assign redirect = id_ex.valid && id_ex.ctrl.branch && (fwd_a == fwd_b);
    assign flush    = redirect;
    assign target   = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{valid: id_ex.valid, ctrl: id_ex.ctrl, alu_result: alu_result,
                        store_data: fwd_b, rd: id_ex.rd};
        end
    end

    // Taken branch must leave a bubble behind it.
    a_redirect_branch: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !id_ex.valid);

endmodule

// File: source/rv_fetch.sv
module rv_fetch import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               load_req,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [31:0]        load_data,
    output logic               load_ack,
    input  logic               stall,
    input  logic               redirect,
    input  logic [31:0]        target,
    output if_id_t             if_id
);

    logic [31:0] imem [imem_words];
    logic [31:0] pc;
    logic [31:0] instr;

    assign instr = imem[pc[imem_aw+1:2]];

    // One write per request, only while the core is idle.
    always_ff @(posedge clk) begin
        if (!run && load_req && !load_ack) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_ack <= 1'b0;
        end else if (!load_req) begin
            load_ack <= 1'b0;
        end else if (!run) begin
            load_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (!run) begin
            // Park at address 0 for the next program.
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (redirect) begin
            pc          <= target;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            pc    <= pc + 32'd4;
            if_id <= '{valid: 1'b1, pc: pc, instr: instr};
        end
    end

    a_no_ack_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        (run && !load_ack) |=> !load_ack);

endmodule

// File: source/rv_memory.sv
module rv_memory import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output store_t  store
);

    logic [31:0]        dmem [dmem_words];
    logic [dmem_aw-1:0] word_addr;
    logic [31:0]        rdata;
    logic               do_write;

    assign word_addr = ex_mem.alu_result[dmem_aw+1:2];
    assign rdata     = dmem[word_addr];
    assign do_write  = ex_mem.valid && ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (do_write) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    assign store = '{valid: do_write, addr: ex_mem.alu_result, data: ex_mem.store_data};

    // Both sources kept; wb_data picks between them.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{valid: ex_mem.valid, reg_write: ex_mem.ctrl.reg_write,
                        mem_to_reg: ex_mem.ctrl.mem_to_reg, alu_result: ex_mem.alu_result,
                        load_data: rdata, rd: ex_mem.rd};
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.valid |-> !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write));

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    localparam int imem_aw    = 8;
    localparam int dmem_aw    = 8;

    // RV32I major opcodes handled by the core.
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_to_reg;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        logic [4:0]  rd;
    } mem_wb_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    // Write-back value of a MEM/WB entry.
    function automatic logic [31:0] wb_data(mem_wb_t e);
        return e.mem_to_reg ? e.load_data : e.alu_result;
    endfunction

endpackage

// File: source/rv_regfile.sv
module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wd
);

    logic [31:0] regs [32];
    logic        wr_en;

    // x0 is never written.
    assign wr_en = we && (rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wd;
        end
    end

    // Write in the same cycle is visible to the reader.
    assign rs1_data = (rs1 == 5'd0) ? '0 : (wr_en && rd == rs1) ? wd : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (wr_en && rd == rs2) ? wd : regs[rs2];

endmodule

// File: test/tb_rv_core.sv
module tb_rv_core import rv_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 3;
    localparam int run_cycles      = 150;
    localparam int drain_cycles    = 8;
    localparam int max_words       = 64;
    localparam int n_tests         = 5;
    localparam int test_cycles     = max_words * 4 + run_cycles + drain_cycles + 4;
    localparam int watchdog_cycles = n_tests * test_cycles + reset_cycles + 100;

    // funct7 and funct3 of the R-type operations.
    localparam logic [9:0] fn_add = 10'b0000000_000;
    localparam logic [9:0] fn_sub = 10'b0100000_000;
    localparam logic [9:0] fn_and = 10'b0000000_111;
    localparam logic [9:0] fn_or  = 10'b0000000_110;
    localparam logic [9:0] fn_slt = 10'b0000000_010;

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               load_req;
    logic [imem_aw-1:0] load_addr;
    logic [31:0]        load_data;
    logic               load_ack;
    retire_t            retire;
    store_t             store;

    logic [31:0] prog [256];
    logic [7:0]  prog_n;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    retire_t     exp_retire [2048];
    store_t      exp_store [2048];
    logic [10:0] exp_retire_n;
    logic [10:0] exp_store_n;
    logic [10:0] retire_idx;
    logic [10:0] store_idx;
    logic        end_of_test;
    logic [31:0] seed = 32'd80739;
    string       test_name;
    int          error_count;
    int          n_pass;
    int          n_fail;

    rv_core i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_ack  (load_ack),
        .retire    (retire),
        .store     (store)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Position in the expected event lists.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_idx <= '0;
            store_idx  <= '0;
        end else begin
            if (retire.valid) retire_idx <= retire_idx + 11'd1;
            if (store.valid) store_idx <= store_idx + 11'd1;
        end
    end

    a_retire_expected: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> retire_idx < exp_retire_n)
        else begin
            $display("%s: register write-back with no write-back left to expect", test_name);
            error_count++;
        end

    a_retire_value: assert property (@(posedge clk) disable iff (!rst_n)
        (retire.valid && retire_idx < exp_retire_n) |-> retire == exp_retire[retire_idx])
        else begin
            $display("ERROR %s retire: expected %h actual %h", test_name,
                     $sampled(exp_retire[retire_idx]), $sampled(retire));
            error_count++;
        end

    a_store_expected: assert property (@(posedge clk) disable iff (!rst_n)
        store.valid |-> store_idx < exp_store_n)
        else begin
            $display("%s: memory write with no memory write left to expect", test_name);
            error_count++;
        end

    a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
        (store.valid && store_idx < exp_store_n) |-> store == exp_store[store_idx])
        else begin
            $display("ERROR %s store: expected %h actual %h", test_name,
                     $sampled(exp_store[store_idx]), $sampled(store));
            error_count++;
        end

    a_all_seen: assert property (@(posedge clk) disable iff (!rst_n)
        end_of_test |-> (retire_idx == exp_retire_n && store_idx == exp_store_n))
        else begin
            $display("%s: some expected write-backs or memory writes never showed up", test_name);
            error_count++;
        end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_ack) |-> $past(load_req))
        else begin
            $display("%s: load_ack rose without a pending load request", test_name);
            error_count++;
        end

    a_ack_drop_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(load_ack) |-> !$past(load_req))
        else begin
            $display("%s: load_ack fell while load_req was still high", test_name);
            error_count++;
        end

    function automatic logic [11:0] random_imm();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[27:16];
    endfunction

    function automatic logic [31:0] r_word(logic [9:0] fn, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_n] = word;
        prog_n++;
    endtask

    // Instruction-level RV32I subset; stops at a beq onto itself.
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_b;
        logic        wr;
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            ins   = prog[pc[9:2]];
            a     = model_regs[ins[19:15]];
            b     = model_regs[ins[24:20]];
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[31:25], ins[14:12]})
                        fn_add:  res = a + b;
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        default: res = {31'd0, $signed(a) < $signed(b)};
                    endcase
                end
                7'b0010011: res = a + {{20{ins[31]}}, ins[31:20]};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    res  = model_mem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    wr   = 1'b0;
                    model_mem[addr[9:2]] = b;
                    exp_store[exp_store_n] = '{valid: 1'b1, addr: addr, data: b};
                    exp_store_n++;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = res;
                exp_retire[exp_retire_n] = '{valid: 1'b1, rd: ins[11:7], data: res};
                exp_retire_n++;
            end
            if (ins[6:0] == 7'b1100011 && a == b) begin
                if (imm_b == 32'd0) break;
                pc = pc + imm_b;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        load_req  = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        while (!load_ack) @(negedge clk);
        load_req = 1'b0;
        @(negedge clk);
        while (load_ack) @(negedge clk);
    endtask

    task automatic load_program(input bit reverse);
        logic [7:0] addr;
        for (int i = 0; i < int'(prog_n); i++) begin
            addr = reverse ? prog_n - 8'(i) - 8'd1 : 8'(i);
            load_word(addr, prog[addr]);
        end
    endtask

    task automatic run_test(input string name, input bit reverse);
        int errs_before;
        errs_before = error_count;
        test_name   = name;
        emit(beq_word(5'd0, 5'd0, 13'd0));
        run_model();
        load_program(reverse);
        @(negedge clk);
        run = 1'b1;
        repeat (run_cycles) @(negedge clk);
        run = 1'b0;
        repeat (drain_cycles) @(negedge clk);
        end_of_test = 1'b1;
        @(negedge clk);
        end_of_test = 1'b0;
        @(negedge clk);
        if (error_count == errs_before) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_loader();
        prog_n = '0;
        emit(addi_word(5'd1, 5'd0, 12'd5));
        emit(addi_word(5'd2, 5'd0, 12'hffd));
        emit(r_word(fn_add, 5'd3, 5'd1, 5'd2));
        emit(r_word(fn_or, 5'd4, 5'd3, 5'd1));
        run_test("loader", 1'b1);
    endtask

    task automatic test_alu();
        prog_n = '0;
        repeat (3) begin
            emit(addi_word(5'd1, 5'd0, random_imm()));
            emit(addi_word(5'd2, 5'd0, random_imm()));
            emit(addi_word(5'd3, 5'd0, random_imm()));
            emit(addi_word(5'd4, 5'd0, random_imm()));
            emit(r_word(fn_add, 5'd5, 5'd1, 5'd2));
            emit(r_word(fn_sub, 5'd6, 5'd3, 5'd4));
            emit(r_word(fn_and, 5'd7, 5'd1, 5'd3));
            emit(r_word(fn_or, 5'd8, 5'd2, 5'd4));
            emit(r_word(fn_slt, 5'd9, 5'd1, 5'd2));
            emit(r_word(fn_slt, 5'd10, 5'd4, 5'd3));
            emit(addi_word(5'd11, 5'd5, random_imm()));
            // x0 must read back as zero right after a write to it.
            emit(r_word(fn_add, 5'd0, 5'd1, 5'd2));
            emit(r_word(fn_add, 5'd12, 5'd0, 5'd0));
        end
        run_test("alu", 1'b0);
    endtask

    task automatic test_forwarding();
        prog_n = '0;
        emit(addi_word(5'd1, 5'd0, random_imm()));
        emit(addi_word(5'd2, 5'd1, random_imm()));
        emit(addi_word(5'd3, 5'd0, random_imm()));
        emit(addi_word(5'd0, 5'd0, 12'd0));
        emit(r_word(fn_add, 5'd4, 5'd3, 5'd1));
        emit(addi_word(5'd5, 5'd0, random_imm()));
        emit(addi_word(5'd0, 5'd0, 12'd0));
        emit(addi_word(5'd0, 5'd0, 12'd0));
        emit(r_word(fn_sub, 5'd6, 5'd5, 5'd2));
        emit(r_word(fn_add, 5'd7, 5'd6, 5'd6));
        emit(addi_word(5'd8, 5'd0, 12'd1));
        emit(addi_word(5'd8, 5'd0, 12'd2));
        emit(r_word(fn_add, 5'd9, 5'd8, 5'd8));
        run_test("forwarding", 1'b0);
    endtask

    task automatic test_load_use();
        prog_n = '0;
        emit(addi_word(5'd1, 5'd0, random_imm()));
        emit(addi_word(5'd2, 5'd0, 12'd64));
        emit(sw_word(5'd1, 5'd2, 12'd0));
        emit(lw_word(5'd3, 5'd2, 12'd0));
        emit(r_word(fn_add, 5'd4, 5'd3, 5'd1));
        emit(sw_word(5'd4, 5'd2, 12'd4));
        emit(lw_word(5'd5, 5'd2, 12'd4));
        emit(sw_word(5'd5, 5'd2, 12'd8));
        emit(lw_word(5'd6, 5'd2, 12'd8));
        emit(addi_word(5'd7, 5'd6, 12'd1));
        emit(r_word(fn_add, 5'd8, 5'd6, 5'd7));
        run_test("load_use", 1'b0);
    endtask

    task automatic test_branches();
        logic [12:0] loop_pc;
        prog_n = '0;
        emit(addi_word(5'd1, 5'd0, 12'd7));
        emit(addi_word(5'd2, 5'd0, 12'd7));
        emit(beq_word(5'd1, 5'd2, 13'd12));
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit(addi_word(5'd4, 5'd0, 12'd2));
        emit(addi_word(5'd5, 5'd0, 12'd3));
        emit(beq_word(5'd1, 5'd0, 13'd8));
        emit(addi_word(5'd6, 5'd0, 12'd4));
        emit(addi_word(5'd7, 5'd0, 12'd5));
        // Countdown loop with a backward branch.
        emit(addi_word(5'd8, 5'd0, 12'd3));
        loop_pc = {3'b000, prog_n, 2'b00};
        emit(addi_word(5'd8, 5'd8, 12'hfff));
        emit(r_word(fn_add, 5'd9, 5'd9, 5'd8));
        emit(beq_word(5'd8, 5'd0, 13'd8));
        emit(beq_word(5'd0, 5'd0, loop_pc - {3'b000, prog_n, 2'b00}));
        emit(addi_word(5'd10, 5'd9, 12'd1));
        run_test("branches", 1'b0);
    endtask

    initial begin
        rst_n        = 1'b0;
        run          = 1'b0;
        load_req     = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        end_of_test  = 1'b0;
        prog_n       = '0;
        exp_retire_n = '0;
        exp_store_n  = '0;
        error_count  = 0;
        n_pass       = 0;
        n_fail       = 0;
        test_name    = "reset";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        test_loader();
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired during test %s, the core or the loader stopped responding",
                 test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
